//--- list.f
+incdir+design
design/wb_pkg.sv
design/dmem_map_pkg.sv
design/dmem_mux3.sv
design/dmem_ram.sv
design/dmem_timer.sv
design/dmem_subsys.sv
testbench/dmem_subsys_tb.sv

//--- testbench/dmem_subsys_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmem_defines.svh"

module dmem_subsys_tb import wb_pkg::*, dmem_map_pkg::*;
();

   localparam int ISSUE_LIMIT = 64;
   localparam int DRAIN_LIMIT = 64;
   localparam int IRQ_LIMIT   = 200;

   typedef enum logic [1:0] {
      OP_WRITE,
      OP_READ,
      OP_IRQ_HIGH,
      OP_IRQ_LOW
   } tb_op_e;

   typedef struct {
      string       test;
      tb_op_e      op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  sel;
      logic        nowait;
      logic        want_stall;
      logic [31:0] exp;
   } entry_t;

   logic        clk_i;
   logic        reset_i;
   logic [31:0] mem_addr_i;
   logic [31:0] mem_data_i;
   logic [31:0] mem_data_o;
   logic [3:0]  mem_sel_i;
   logic        mem_we_i;
   logic        mem_stb_i;
   logic        mem_cyc_i;
   wb_cti_e     mem_cti_i;
   logic        mem_ack_o;
   logic        mem_stall_o;
   logic [31:0] ext_addr_o;
   logic [31:0] ext_data_o;
   logic [31:0] ext_data_i;
   logic [3:0]  ext_sel_o;
   logic        ext_we_o;
   logic        ext_stb_o;
   logic        ext_cyc_o;
   wb_cti_e     ext_cti_o;
   logic        ext_ack_i;
   logic        ext_stall_i;
   logic        irq_o;

   // Request held on the master port until accepted
   logic        hold_reset;
   logic        pend_valid;
   logic        pend_we;
   logic [31:0] pend_addr;
   logic [31:0] pend_data;
   logic [3:0]  pend_sel;
   wb_cti_e     pend_cti;
   logic [31:0] pend_exp;
   logic        pend_chk;
   string       pend_name;
   logic        saw_stall;
   logic        timed_out;

   // Expected responses in request order
   logic [31:0] exp_data_q [$];
   logic        exp_chk_q [$];
   string       exp_name_q [$];

   logic [31:0] ram_shadow [2**`DMEM_RAM_AW];
   logic [31:0] ext_shadow [256];
   logic [31:0] ext_mem [256];
   int          resp_due_q [$];
   logic [31:0] resp_data_q [$];

   entry_t      tbl [$];
   int          cyc_no;
   int          acc_cnt;
   int          ack_cnt;
   int          chk_cnt;
   int          err_cnt;
   int          test_err_base;

   dmem_subsys dmem_subsys_i
   (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .mem_addr_i  (mem_addr_i),
      .mem_data_i  (mem_data_i),
      .mem_data_o  (mem_data_o),
      .mem_sel_i   (mem_sel_i),
      .mem_we_i    (mem_we_i),
      .mem_stb_i   (mem_stb_i),
      .mem_cyc_i   (mem_cyc_i),
      .mem_cti_i   (mem_cti_i),
      .mem_ack_o   (mem_ack_o),
      .mem_stall_o (mem_stall_o),
      .ext_addr_o  (ext_addr_o),
      .ext_data_o  (ext_data_o),
      .ext_data_i  (ext_data_i),
      .ext_sel_o   (ext_sel_o),
      .ext_we_o    (ext_we_o),
      .ext_stb_o   (ext_stb_o),
      .ext_cyc_o   (ext_cyc_o),
      .ext_cti_o   (ext_cti_o),
      .ext_ack_i   (ext_ack_i),
      .ext_stall_i (ext_stall_i),
      .irq_o       (irq_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever
      begin
         #5 clk_i = ~clk_i;
      end
   end

   function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  lanes);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++)
      begin
         if (lanes[b])
            res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [31:0] map_addr(input dmem_port_e port, input int offset);
      return (32'(port) << `DMEM_ADDR_MUX_START) | 32'(offset);
   endfunction

   function automatic void add_row(input string test, input tb_op_e op,
                                   input logic [31:0] addr, input logic [31:0] data,
                                   input logic [3:0] sel, input logic nowait,
                                   input logic want_stall, input logic [31:0] exp);
      entry_t e;
      e = '{test, op, addr, data, sel, nowait, want_stall, exp};
      tbl.push_back(e);
   endfunction

   // External slave: random stall, acks in order after 1 to 4 cycles
   task automatic drive_slave();
      ext_ack_i   = 1'b0;
      ext_data_i  = $urandom();
      ext_stall_i = !hold_reset && ($urandom() % 4 == 0);
      if (resp_due_q.size() != 0 && resp_due_q[0] <= cyc_no)
      begin
         void'(resp_due_q.pop_front());
         ext_ack_i  = 1'b1;
         ext_data_i = resp_data_q.pop_front();
      end
   endtask

   task automatic sample_slave();
      logic [7:0] idx;
      int         due;
      if (ext_stb_o && !ext_stall_i)
      begin
         idx = ext_addr_o[9:2];
         chk_cnt++;
         assert (ext_cyc_o)
         else
         begin
            $display("%0t: external strobe accepted without cyc", $time);
            err_cnt++;
         end
         // Cycle type tag passes through unchanged
         chk_cnt++;
         assert (ext_cti_o === pend_cti)
         else
         begin
            $display("MISMATCH %0t ext_cti_o: expected %0d, got %0d",
                     $time, pend_cti, ext_cti_o);
            err_cnt++;
         end
         if (ext_we_o)
            ext_mem[idx] = lane_merge(ext_mem[idx], ext_data_o, ext_sel_o);
         due = cyc_no + 1 + int'($urandom() % 4);
         if (resp_due_q.size() != 0 && due <= resp_due_q[$])
            due = resp_due_q[$] + 1;
         resp_due_q.push_back(due);
         resp_data_q.push_back(ext_mem[idx]);
      end
   endtask

   task automatic collect_ack();
      logic [31:0] want;
      logic        chk;
      string       nm;
      ack_cnt++;
      chk_cnt++;
      assert (exp_data_q.size() != 0)
      else
      begin
         $display("%0t: ack arrived with no request outstanding", $time);
         err_cnt++;
      end
      if (exp_data_q.size() != 0)
      begin
         want = exp_data_q.pop_front();
         chk  = exp_chk_q.pop_front();
         nm   = exp_name_q.pop_front();
         if (chk)
         begin
            chk_cnt++;
            assert (mem_data_o === want)
            else
            begin
               $display("MISMATCH %0t mem_data_o (%s): expected %h, got %h",
                        $time, nm, want, mem_data_o);
               err_cnt++;
            end
         end
      end
   endtask

   // One clock: drive on the falling edge, sample once things settle
   task automatic tick();
      @(negedge clk_i);
      cyc_no++;
      reset_i    = hold_reset;
      mem_addr_i = pend_addr;
      mem_data_i = pend_data;
      mem_sel_i  = pend_sel;
      mem_we_i   = pend_we;
      mem_cti_i  = pend_cti;
      mem_stb_i  = pend_valid;
      mem_cyc_i  = pend_valid || (exp_data_q.size() != 0);
      drive_slave();
      #1;
      if (mem_ack_o)
         collect_ack();
      if (mem_stb_i && mem_addr_i[`DMEM_ADDR_MUX_START +: 2] == PORT_NONE)
      begin
         chk_cnt++;
         assert (!ext_stb_o && !dmem_subsys_i.ram_stb && !dmem_subsys_i.tmr_stb)
         else
         begin
            $display("%0t: unmapped access raised a port strobe", $time);
            err_cnt++;
         end
      end
      // Held off by the decoder, not by the external slave
      if (mem_stb_i && mem_stall_o && !ext_stb_o)
         saw_stall = 1'b1;
      if (mem_stb_i && !mem_stall_o)
      begin
         exp_data_q.push_back(pend_exp);
         exp_chk_q.push_back(pend_chk);
         exp_name_q.push_back(pend_name);
         acc_cnt++;
         pend_valid = 1'b0;
      end
      sample_slave();
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (exp_data_q.size() != 0 && waited < DRAIN_LIMIT)
      begin
         tick();
         waited++;
      end
      if (exp_data_q.size() != 0)
      begin
         $display("%0t: %0d acks still missing after %0d cycles",
                  $time, exp_data_q.size(), DRAIN_LIMIT);
         timed_out = 1'b1;
         err_cnt++;
      end
   endtask

   task automatic issue(input entry_t e);
      dmem_port_e               port;
      logic [`DMEM_RAM_AW-1:0]  widx;
      int                       waited;
      port     = dmem_port_e'(e.addr[`DMEM_ADDR_MUX_START +: 2]);
      widx     = e.addr[`DMEM_RAM_AW+1:2];
      pend_chk = (e.op == OP_READ);
      pend_exp = e.exp;
      // Reads of RAM and external words expect the last bytes written there
      if (e.op == OP_WRITE && port == PORT_RAM)
         ram_shadow[widx] = lane_merge(ram_shadow[widx], e.data, e.sel);
      else if (e.op == OP_WRITE && port == PORT_EXT)
         ext_shadow[widx[7:0]] = lane_merge(ext_shadow[widx[7:0]], e.data, e.sel);
      else if (port == PORT_RAM)
         pend_exp = ram_shadow[widx];
      else if (port == PORT_EXT)
         pend_exp = ext_shadow[widx[7:0]];
      pend_name  = e.test;
      pend_we    = (e.op == OP_WRITE);
      pend_addr  = e.addr;
      pend_data  = e.data;
      pend_sel   = e.sel;
      // Pipelined runs are tagged as a burst whose last request ends it
      pend_cti   = e.nowait ? WB_CTI_INCR : WB_CTI_EOB;
      pend_valid = 1'b1;
      saw_stall  = 1'b0;
      waited     = 0;
      while (pend_valid && waited < ISSUE_LIMIT)
      begin
         tick();
         waited++;
      end
      if (pend_valid)
      begin
         $display("%0t: %s request was never accepted", $time, e.test);
         pend_valid = 1'b0;
         timed_out  = 1'b1;
         err_cnt++;
      end
      else if (e.want_stall)
      begin
         chk_cnt++;
         assert (saw_stall)
         else
         begin
            $display("%0t: %s request to a new port was not held off", $time, e.test);
            err_cnt++;
         end
      end
      if (!e.nowait)
         drain();
   endtask

   task automatic run_row(input entry_t e);
      int waited;
      case (e.op)
         OP_IRQ_HIGH:
         begin
            drain();
            waited = 0;
            while (!irq_o && waited < IRQ_LIMIT)
            begin
               tick();
               waited++;
            end
            chk_cnt++;
            assert (irq_o)
            else
            begin
               $display("%0t: timer interrupt did not rise within %0d cycles",
                        $time, IRQ_LIMIT);
               timed_out = 1'b1;
               err_cnt++;
            end
         end
         OP_IRQ_LOW:
         begin
            drain();
            tick();
            chk_cnt++;
            assert (!irq_o)
            else
            begin
               $display("MISMATCH %0t irq_o: expected 0, got %b", $time, irq_o);
               err_cnt++;
            end
         end
         default:
            issue(e);
      endcase
   endtask

   task automatic finish_test(input string test);
      drain();
      chk_cnt++;
      assert (ack_cnt == acc_cnt)
      else
      begin
         $display("%0t: %0d requests accepted but %0d acks seen", $time, acc_cnt, ack_cnt);
         err_cnt++;
      end
      if (err_cnt == test_err_base)
         $display("test %-14s ok", test);
      else
         $display("test %-14s failed with %0d errors", test, err_cnt - test_err_base);
      test_err_base = err_cnt;
   endtask

   initial
   begin
      void'($urandom(57907));
      reset_i       = 1'b1;
      mem_addr_i    = 32'h0;
      mem_data_i    = 32'h0;
      mem_sel_i     = 4'b0000;
      mem_we_i      = 1'b0;
      mem_stb_i     = 1'b0;
      mem_cyc_i     = 1'b0;
      mem_cti_i     = WB_CTI_CLASSIC;
      ext_data_i    = 32'h0;
      ext_ack_i     = 1'b0;
      ext_stall_i   = 1'b0;
      hold_reset    = 1'b1;
      pend_valid    = 1'b0;
      pend_we       = 1'b0;
      pend_addr     = 32'h0;
      pend_data     = 32'h0;
      pend_sel      = 4'b0000;
      pend_cti      = WB_CTI_CLASSIC;
      pend_exp      = 32'h0;
      pend_chk      = 1'b0;
      pend_name     = "";
      saw_stall     = 1'b0;
      timed_out     = 1'b0;
      cyc_no        = 0;
      acc_cnt       = 0;
      ack_cnt       = 0;
      chk_cnt       = 0;
      err_cnt       = 0;
      test_err_base = 0;
      for (int i = 0; i < 256; i++)
      begin
         ext_mem[i]    = {24'hE5A5C3, 8'(i)};
         ext_shadow[i] = {24'hE5A5C3, 8'(i)};
      end

      add_row("ram_bytes", OP_WRITE, map_addr(PORT_RAM, 'h010), 32'h1122_3344, 4'hF, 0, 0, 0);
      add_row("ram_bytes", OP_WRITE, map_addr(PORT_RAM, 'h010), 32'hAABB_CCDD, 4'h5, 0, 0, 0);
      add_row("ram_bytes", OP_READ,  map_addr(PORT_RAM, 'h010), 32'h0, 4'hF, 0, 0, 0);
      add_row("ram_bytes", OP_WRITE, map_addr(PORT_RAM, 'h014), 32'h0102_0304, 4'hF, 1, 0, 0);
      add_row("ram_bytes", OP_WRITE, map_addr(PORT_RAM, 'h014), 32'hFFFF_FFFF, 4'h8, 1, 0, 0);
      add_row("ram_bytes", OP_WRITE, map_addr(PORT_RAM, 'h014), 32'h5555_AAAA, 4'h2, 1, 0, 0);
      add_row("ram_bytes", OP_READ,  map_addr(PORT_RAM, 'h014), 32'h0, 4'hF, 0, 0, 0);
      add_row("ram_pipe",  OP_WRITE, map_addr(PORT_RAM, 'h100), 32'hA0A0_0001, 4'hF, 1, 0, 0);
      add_row("ram_pipe",  OP_WRITE, map_addr(PORT_RAM, 'h104), 32'hA0A0_0002, 4'hF, 1, 0, 0);
      add_row("ram_pipe",  OP_WRITE, map_addr(PORT_RAM, 'h108), 32'hA0A0_0003, 4'hF, 1, 0, 0);
      add_row("ram_pipe",  OP_WRITE, map_addr(PORT_RAM, 'h10C), 32'hA0A0_0004, 4'hF, 1, 0, 0);
      add_row("ram_pipe",  OP_READ,  map_addr(PORT_RAM, 'h100), 32'h0, 4'hF, 1, 0, 0);
      add_row("ram_pipe",  OP_READ,  map_addr(PORT_RAM, 'h104), 32'h0, 4'hF, 1, 0, 0);
      add_row("ram_pipe",  OP_READ,  map_addr(PORT_RAM, 'h108), 32'h0, 4'hF, 1, 0, 0);
      add_row("ram_pipe",  OP_READ,  map_addr(PORT_RAM, 'h10C), 32'h0, 4'hF, 0, 0, 0);
      add_row("ext_after_ram", OP_READ,  map_addr(PORT_RAM, 'h108), 32'h0, 4'hF, 1, 0, 0);
      add_row("ext_after_ram", OP_READ,  map_addr(PORT_RAM, 'h104), 32'h0, 4'hF, 1, 0, 0);
      add_row("ext_after_ram", OP_READ,  map_addr(PORT_RAM, 'h100), 32'h0, 4'hF, 1, 0, 0);
      add_row("ext_after_ram", OP_READ,  map_addr(PORT_EXT, 'h000), 32'h0, 4'hF, 1, 1, 0);
      add_row("ext_after_ram", OP_WRITE, map_addr(PORT_EXT, 'h020), 32'hDEAD_BEEF, 4'hF, 1, 0, 0);
      add_row("ext_after_ram", OP_WRITE, map_addr(PORT_EXT, 'h024), 32'h1234_5678, 4'hF, 1, 0, 0);
      add_row("ext_after_ram", OP_WRITE, map_addr(PORT_EXT, 'h024), 32'h0000_ABCD, 4'h3, 1, 0, 0);
      add_row("ext_after_ram", OP_READ,  map_addr(PORT_EXT, 'h020), 32'h0, 4'hF, 1, 0, 0);
      add_row("ext_after_ram", OP_READ,  map_addr(PORT_EXT, 'h024), 32'h0, 4'hF, 1, 0, 0);
      add_row("ext_after_ram", OP_READ,  map_addr(PORT_EXT, 'h028), 32'h0, 4'hF, 0, 0, 0);
      add_row("timer_irq", OP_WRITE, map_addr(PORT_TIMER, 4 * TMR_COUNT), 0, 4'hF, 0, 0, 0);
      add_row("timer_irq", OP_WRITE, map_addr(PORT_TIMER, 4 * TMR_COMPARE), 20, 4'hF, 0, 0, 0);
      add_row("timer_irq", OP_WRITE, map_addr(PORT_TIMER, 4 * TMR_CONTROL), 1, 4'hF, 0, 0, 0);
      add_row("timer_irq", OP_IRQ_HIGH, 32'h0, 32'h0, 4'h0, 0, 0, 0);
      add_row("timer_irq", OP_READ,  map_addr(PORT_TIMER, 4 * TMR_STATUS), 0, 4'hF, 0, 0, 1);
      add_row("timer_irq", OP_WRITE, map_addr(PORT_TIMER, 4 * TMR_STATUS), 1, 4'h1, 0, 0, 0);
      add_row("timer_irq", OP_IRQ_LOW, 32'h0, 32'h0, 4'h0, 0, 0, 0);
      add_row("timer_irq", OP_READ,  map_addr(PORT_TIMER, 4 * TMR_STATUS), 0, 4'hF, 0, 0, 0);
      add_row("timer_count", OP_WRITE, map_addr(PORT_TIMER, 4 * TMR_CONTROL), 0, 4'hF, 0, 0, 0);
      add_row("timer_count", OP_WRITE, map_addr(PORT_TIMER, 4 * TMR_COUNT), 'h1234, 4'hF, 0, 0, 0);
      add_row("timer_count", OP_READ, map_addr(PORT_TIMER, 4 * TMR_COUNT), 0, 4'hF, 0, 0, 'h1234);
      add_row("timer_count", OP_READ, map_addr(PORT_TIMER, 4 * TMR_COMPARE), 0, 4'hF, 0, 0, 20);
      add_row("unmapped", OP_READ,  map_addr(PORT_NONE, 'h040), 32'h0, 4'hF, 0, 0, 0);
      add_row("unmapped", OP_WRITE, map_addr(PORT_NONE, 'h044), 32'hFFFF_FFFF, 4'hF, 1, 0, 0);
      add_row("unmapped", OP_READ,  map_addr(PORT_NONE, 'h040), 32'h0, 4'hF, 0, 0, 0);

      repeat (10)
         tick();
      hold_reset = 1'b0;
      tick();
      chk_cnt++;
      assert ({mem_ack_o, mem_stall_o, irq_o, ext_stb_o} === 4'b0000)
      else
      begin
         $display("MISMATCH %0t {mem_ack_o, mem_stall_o, irq_o, ext_stb_o}: expected 0000, got %b",
                  $time, {mem_ack_o, mem_stall_o, irq_o, ext_stb_o});
         err_cnt++;
      end
      finish_test("reset");

      for (int i = 0; i < tbl.size() && !timed_out; i++)
      begin
         run_row(tbl[i]);
         if (i == tbl.size() - 1 || tbl[i + 1].test != tbl[i].test)
            finish_test(tbl[i].test);
      end

      $display("checks %0d, errors %0d, accepted %0d, acked %0d",
               chk_cnt, err_cnt, acc_cnt, ack_cnt);
      if (err_cnt == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- design/dmem_subsys.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmem_defines.svh"

module dmem_subsys import wb_pkg::*;
(
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic [31:0] mem_addr_i,
   input  logic [31:0] mem_data_i,
   output logic [31:0] mem_data_o,
   input  logic [3:0]  mem_sel_i,
   input  logic        mem_we_i,
   input  logic        mem_stb_i,
   input  logic        mem_cyc_i,
   input  wb_cti_e     mem_cti_i,
   output logic        mem_ack_o,
   output logic        mem_stall_o,
   output logic [31:0] ext_addr_o,
   output logic [31:0] ext_data_o,
   input  logic [31:0] ext_data_i,
   output logic [3:0]  ext_sel_o,
   output logic        ext_we_o,
   output logic        ext_stb_o,
   output logic        ext_cyc_o,
   output wb_cti_e     ext_cti_o,
   input  logic        ext_ack_i,
   input  logic        ext_stall_i,
   output logic        irq_o
);

   logic [31:0] ram_addr;
   logic [31:0] ram_wdata;
   logic [31:0] ram_rdata;
   logic [3:0]  ram_sel;
   logic        ram_we;
   logic        ram_stb;
   logic        ram_cyc;
   logic        ram_ack;
   logic        ram_stall;
   logic [31:0] tmr_addr;
   logic [31:0] tmr_wdata;
   logic [31:0] tmr_rdata;
   logic [3:0]  tmr_sel;
   logic        tmr_we;
   logic        tmr_stb;
   logic        tmr_cyc;
   logic        tmr_ack;
   logic        tmr_stall;

   dmem_mux3
   #(
      .ADDR_MUX_START (`DMEM_ADDR_MUX_START)
   )
   mux_i
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .mem_addr_i   (mem_addr_i),
      .mem_data_i   (mem_data_i),
      .mem_data_o   (mem_data_o),
      .mem_sel_i    (mem_sel_i),
      .mem_we_i     (mem_we_i),
      .mem_stb_i    (mem_stb_i),
      .mem_cyc_i    (mem_cyc_i),
      .mem_cti_i    (mem_cti_i),
      .mem_ack_o    (mem_ack_o),
      .mem_stall_o  (mem_stall_o),
      .out0_addr_o  (ram_addr),
      .out0_data_o  (ram_wdata),
      .out0_data_i  (ram_rdata),
      .out0_sel_o   (ram_sel),
      .out0_we_o    (ram_we),
      .out0_stb_o   (ram_stb),
      .out0_cyc_o   (ram_cyc),
      .out0_cti_o   (),
      .out0_ack_i   (ram_ack),
      .out0_stall_i (ram_stall),
      .out1_addr_o  (tmr_addr),
      .out1_data_o  (tmr_wdata),
      .out1_data_i  (tmr_rdata),
      .out1_sel_o   (tmr_sel),
      .out1_we_o    (tmr_we),
      .out1_stb_o   (tmr_stb),
      .out1_cyc_o   (tmr_cyc),
      .out1_cti_o   (),
      .out1_ack_i   (tmr_ack),
      .out1_stall_i (tmr_stall),
      .out2_addr_o  (ext_addr_o),
      .out2_data_o  (ext_data_o),
      .out2_data_i  (ext_data_i),
      .out2_sel_o   (ext_sel_o),
      .out2_we_o    (ext_we_o),
      .out2_stb_o   (ext_stb_o),
      .out2_cyc_o   (ext_cyc_o),
      .out2_cti_o   (ext_cti_o),
      .out2_ack_i   (ext_ack_i),
      .out2_stall_i (ext_stall_i)
   );

   dmem_ram
   #(
      .RAM_AW (`DMEM_RAM_AW)
   )
   ram_i
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .addr_i  (ram_addr),
      .data_i  (ram_wdata),
      .data_o  (ram_rdata),
      .sel_i   (ram_sel),
      .we_i    (ram_we),
      .stb_i   (ram_stb),
      .cyc_i   (ram_cyc),
      .ack_o   (ram_ack),
      .stall_o (ram_stall)
   );

   dmem_timer timer_i
   (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .addr_i  (tmr_addr),
      .data_i  (tmr_wdata),
      .data_o  (tmr_rdata),
      .sel_i   (tmr_sel),
      .we_i    (tmr_we),
      .stb_i   (tmr_stb),
      .cyc_i   (tmr_cyc),
      .ack_o   (tmr_ack),
      .stall_o (tmr_stall),
      .irq_o   (irq_o)
   );

endmodule

`default_nettype wire

//--- design/dmem_timer.sv
`timescale 1ns/10ps
`default_nettype none

module dmem_timer import dmem_map_pkg::*;
(
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic [31:0] addr_i,
   input  logic [31:0] data_i,
   output logic [31:0] data_o,
   input  logic [3:0]  sel_i,
   input  logic        we_i,
   input  logic        stb_i,
   input  logic        cyc_i,
   output logic        ack_o,
   output logic        stall_o,
   output logic        irq_o
);

   timer_reg_e  reg_sel;
   logic [31:0] count_q;
   logic [31:0] compare_q;
   logic        enable_q;
   logic        match_q;
   logic        match_d;
   logic        match_set;
   logic        status_clr;
   logic        accept;
   logic        wr_en;

   function automatic logic [31:0] merge_bytes(
      input logic [31:0] old_val,
      input logic [31:0] new_val,
      input logic [3:0]  lanes
   );
      logic [31:0] res;
      res = old_val;
      for (int b = 0; b < 4; b++)
      begin
         if (lanes[b])
         begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

   assign reg_sel    = timer_reg_e'(addr_i[3:2]);
   assign stall_o    = 1'b0;
   assign accept     = stb_i & cyc_i;
   assign wr_en      = accept & we_i;
   assign status_clr = wr_en && (reg_sel == TMR_STATUS) && sel_i[0] && data_i[0];
   assign match_set  = enable_q && (count_q == compare_q);
   // A new match beats a clear in the same cycle
   assign match_d    = match_set | (match_q & ~status_clr);

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         count_q   <= 32'h0;
         compare_q <= 32'h0;
         enable_q  <= 1'b0;
         match_q   <= 1'b0;
         irq_o     <= 1'b0;
         ack_o     <= 1'b0;
      end
      else
      begin
         ack_o   <= accept;
         match_q <= match_d;
         irq_o   <= match_d;
         if (wr_en && reg_sel == TMR_COUNT)
         begin
            count_q <= merge_bytes(count_q, data_i, sel_i);
         end
         else if (enable_q)
         begin
            count_q <= count_q + 1'b1;
         end
         if (wr_en && reg_sel == TMR_COMPARE)
         begin
            compare_q <= merge_bytes(compare_q, data_i, sel_i);
         end
         if (wr_en && reg_sel == TMR_CONTROL && sel_i[0])
         begin
            enable_q <= data_i[0];
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         case (reg_sel)
            TMR_COUNT:   data_o <= count_q;
            TMR_COMPARE: data_o <= compare_q;
            TMR_CONTROL: data_o <= {31'h0, enable_q};
            default:     data_o <= {31'h0, match_q};
         endcase
      end
   end

   a_irq_has_match: assert property (@(posedge clk_i) disable iff (reset_i)
      irq_o |-> match_q)
      else $error("Timer interrupt raised without a match");

endmodule

`default_nettype wire

//--- design/dmem_ram.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmem_defines.svh"

module dmem_ram
#(
   parameter int RAM_AW = `DMEM_RAM_AW
)
(
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic [31:0] addr_i,
   input  logic [31:0] data_i,
   output logic [31:0] data_o,
   input  logic [3:0]  sel_i,
   input  logic        we_i,
   input  logic        stb_i,
   input  logic        cyc_i,
   output logic        ack_o,
   output logic        stall_o
);

   logic [31:0]       mem_q [2**RAM_AW];
   logic [RAM_AW-1:0] word_idx;
   logic              accept;

   assign word_idx = addr_i[RAM_AW+1:2];
   assign stall_o  = 1'b0;
   assign accept   = stb_i & cyc_i;

   // Byte lanes written only where sel_i is set
   always_ff @(posedge clk_i)
   begin
      if (accept && we_i)
      begin
         for (int b = 0; b < 4; b++)
         begin
            if (sel_i[b])
            begin
               mem_q[word_idx][8*b +: 8] <= data_i[8*b +: 8];
            end
         end
      end
      if (accept)
      begin
         data_o <= mem_q[word_idx];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         ack_o <= 1'b0;
      end
      else
      begin
         ack_o <= accept;
      end
   end

   a_ack_follows: assert property (@(posedge clk_i) disable iff (reset_i)
      ack_o == $past(accept && !stall_o && !reset_i))
      else $error("RAM ack does not trail its request by one cycle");

endmodule

`default_nettype wire

//--- design/dmem_mux3.sv
`timescale 1ns/10ps
`default_nettype none
`include "dmem_defines.svh"

module dmem_mux3 import wb_pkg::*, dmem_map_pkg::*;
#(
   parameter int ADDR_MUX_START = `DMEM_ADDR_MUX_START
)
(
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic [31:0] mem_addr_i,
   input  logic [31:0] mem_data_i,
   output logic [31:0] mem_data_o,
   input  logic [3:0]  mem_sel_i,
   input  logic        mem_we_i,
   input  logic        mem_stb_i,
   input  logic        mem_cyc_i,
   input  wb_cti_e     mem_cti_i,
   output logic        mem_ack_o,
   output logic        mem_stall_o,
   output logic [31:0] out0_addr_o,
   output logic [31:0] out0_data_o,
   input  logic [31:0] out0_data_i,
   output logic [3:0]  out0_sel_o,
   output logic        out0_we_o,
   output logic        out0_stb_o,
   output logic        out0_cyc_o,
   output wb_cti_e     out0_cti_o,
   input  logic        out0_ack_i,
   input  logic        out0_stall_i,
   output logic [31:0] out1_addr_o,
   output logic [31:0] out1_data_o,
   input  logic [31:0] out1_data_i,
   output logic [3:0]  out1_sel_o,
   output logic        out1_we_o,
   output logic        out1_stb_o,
   output logic        out1_cyc_o,
   output wb_cti_e     out1_cti_o,
   input  logic        out1_ack_i,
   input  logic        out1_stall_i,
   output logic [31:0] out2_addr_o,
   output logic [31:0] out2_data_o,
   input  logic [31:0] out2_data_i,
   output logic [3:0]  out2_sel_o,
   output logic        out2_we_o,
   output logic        out2_stb_o,
   output logic        out2_cyc_o,
   output wb_cti_e     out2_cti_o,
   input  logic        out2_ack_i,
   input  logic        out2_stall_i
);

   typedef enum logic {
      MUX_IDLE,
      MUX_BUSY
   } dmem_mux3_state_e;

   localparam int CNT_W = $clog2(`DMEM_MAX_OUTSTANDING + 1);

   dmem_mux3_state_e state_q;
   dmem_port_e       owner_q;
   dmem_port_e       port_sel;
   dmem_port_e       resp_port;
   logic [CNT_W-1:0] out_cnt_q;
   logic [CNT_W-1:0] out_cnt_d;
   logic [2:0]       hit;
   logic [2:0]       owns;
   logic             block;
   logic             port_stall;
   logic             accept;
   logic             none_ack_q;

   assign port_sel = dmem_port_e'(mem_addr_i[ADDR_MUX_START+1:ADDR_MUX_START]);

   assign hit[0] = (port_sel == PORT_RAM);
   assign hit[1] = (port_sel == PORT_TIMER);
   assign hit[2] = (port_sel == PORT_EXT);

   // Port that still owes acks keeps its cycle open
   assign owns[0] = (state_q == MUX_BUSY) && (owner_q == PORT_RAM);
   assign owns[1] = (state_q == MUX_BUSY) && (owner_q == PORT_TIMER);
   assign owns[2] = (state_q == MUX_BUSY) && (owner_q == PORT_EXT);

   // Hold back a port switch until the owner has drained
   assign block = ((state_q == MUX_BUSY) && (port_sel != owner_q)) ||
                  (out_cnt_q == CNT_W'(`DMEM_MAX_OUTSTANDING));

   always_comb
   begin
      case (port_sel)
         PORT_RAM:   port_stall = out0_stall_i;
         PORT_TIMER: port_stall = out1_stall_i;
         PORT_EXT:   port_stall = out2_stall_i;
         default:    port_stall = 1'b0;
      endcase
   end

   assign mem_stall_o = block | port_stall;
   assign accept      = mem_stb_i & mem_cyc_i & ~mem_stall_o;

   // Unselected ports see all zeros
   assign out0_addr_o = hit[0] ? mem_addr_i : 32'h0;
   assign out0_data_o = hit[0] ? mem_data_i : 32'h0;
   assign out0_sel_o  = hit[0] ? mem_sel_i : 4'b0000;
   assign out0_we_o   = hit[0] & mem_we_i;
   assign out0_stb_o  = hit[0] & mem_stb_i & ~block;
   assign out0_cyc_o  = mem_cyc_i & (hit[0] | owns[0]);
   assign out0_cti_o  = hit[0] ? mem_cti_i : WB_CTI_CLASSIC;

   assign out1_addr_o = hit[1] ? mem_addr_i : 32'h0;
   assign out1_data_o = hit[1] ? mem_data_i : 32'h0;
   assign out1_sel_o  = hit[1] ? mem_sel_i : 4'b0000;
   assign out1_we_o   = hit[1] & mem_we_i;
   assign out1_stb_o  = hit[1] & mem_stb_i & ~block;
   assign out1_cyc_o  = mem_cyc_i & (hit[1] | owns[1]);
   assign out1_cti_o  = hit[1] ? mem_cti_i : WB_CTI_CLASSIC;

   assign out2_addr_o = hit[2] ? mem_addr_i : 32'h0;
   assign out2_data_o = hit[2] ? mem_data_i : 32'h0;
   assign out2_sel_o  = hit[2] ? mem_sel_i : 4'b0000;
   assign out2_we_o   = hit[2] & mem_we_i;
   assign out2_stb_o  = hit[2] & mem_stb_i & ~block;
   assign out2_cyc_o  = mem_cyc_i & (hit[2] | owns[2]);
   assign out2_cti_o  = hit[2] ? mem_cti_i : WB_CTI_CLASSIC;

   // Responses come from the owner while busy
   assign resp_port = (state_q == MUX_BUSY) ? owner_q : port_sel;

   always_comb
   begin
      case (resp_port)
         PORT_RAM:
         begin
            mem_ack_o  = out0_ack_i;
            mem_data_o = out0_data_i;
         end
         PORT_TIMER:
         begin
            mem_ack_o  = out1_ack_i;
            mem_data_o = out1_data_i;
         end
         PORT_EXT:
         begin
            mem_ack_o  = out2_ack_i;
            mem_data_o = out2_data_i;
         end
         default:
         begin
            mem_ack_o  = none_ack_q;
            mem_data_o = 32'h0;
         end
      endcase
   end

   always_comb
   begin
      out_cnt_d = out_cnt_q;
      if (accept && !mem_ack_o)
      begin
         out_cnt_d = out_cnt_q + 1'b1;
      end
      else if (!accept && mem_ack_o)
      begin
         out_cnt_d = out_cnt_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_q    <= MUX_IDLE;
         owner_q    <= PORT_NONE;
         out_cnt_q  <= '0;
         none_ack_q <= 1'b0;
      end
      else
      begin
         out_cnt_q  <= out_cnt_d;
         state_q    <= (out_cnt_d != '0) ? MUX_BUSY : MUX_IDLE;
         // Unmapped access gets an empty ack next cycle
         none_ack_q <= accept && (port_sel == PORT_NONE);
         if (accept)
         begin
            owner_q <= port_sel;
         end
      end
   end

   a_ram_ack_owned: assert property (@(posedge clk_i) disable iff (reset_i)
      out0_ack_i |-> owns[0])
      else $error("RAM port acked with nothing outstanding");

   a_tmr_ack_owned: assert property (@(posedge clk_i) disable iff (reset_i)
      out1_ack_i |-> owns[1])
      else $error("Timer port acked with nothing outstanding");

   a_ext_ack_owned: assert property (@(posedge clk_i) disable iff (reset_i)
      out2_ack_i |-> owns[2])
      else $error("External port acked with nothing outstanding");

   a_resp_known: assert property (@(posedge clk_i) disable iff (reset_i)
      !$isunknown({mem_stall_o, mem_ack_o}))
      else $error("Master stall or ack is unknown");

endmodule

`default_nettype wire

//--- design/dmem_map_pkg.sv
`default_nettype none

package dmem_map_pkg;

   // Value of the port field in the address
   typedef enum logic [1:0] {
      PORT_RAM   = 2'd0,
      PORT_TIMER = 2'd1,
      PORT_EXT   = 2'd2,
      PORT_NONE  = 2'd3
   } dmem_port_e;

   // Timer register word offsets, address bits 3:2
   typedef enum logic [1:0] {
      TMR_COUNT   = 2'd0,
      TMR_COMPARE = 2'd1,
      TMR_CONTROL = 2'd2,
      TMR_STATUS  = 2'd3
   } timer_reg_e;

endpackage

`default_nettype wire

//--- design/wb_pkg.sv
`default_nettype none

package wb_pkg;

   // Cycle type tag carried on cti
   typedef enum logic [2:0] {
      WB_CTI_CLASSIC = 3'b000,
      WB_CTI_CONST   = 3'b001,
      WB_CTI_INCR    = 3'b010,
      WB_CTI_EOB     = 3'b111
   } wb_cti_e;

endpackage

`default_nettype wire

//--- design/dmem_defines.svh
`ifndef DMEM_DEFINES_SVH
`define DMEM_DEFINES_SVH

// Address map of the data-memory subsystem.
// Bits [MUX_START+1:MUX_START] of a byte address pick the target port.

// Lowest address bit of the two-bit port select field
`define DMEM_ADDR_MUX_START 28

// Word-address width of the on-chip RAM
// 10 bits of 32-bit words make 4 KB
`define DMEM_RAM_AW 10

// Most requests that may be in flight through the decoder at once
`define DMEM_MAX_OUTSTANDING 3

`endif
